// ==== design/rot_reg_pkg.sv ====
package rot_reg_pkg;

	localparam int WORD_W = 32;
	localparam int ADDR_W = 8;
	localparam int KEY_WORDS = 4;
	localparam int BIT_IDX_W = $clog2(WORD_W);
	localparam int TRNG_CNT_W = 3; // enough for the draw limit

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [$clog2(KEY_WORDS)-1:0] sel_word_t;
	typedef logic [BIT_IDX_W-1:0] bit_idx_t;

	localparam addr_t ADDR_OP = 8'h00;
	localparam addr_t ADDR_STATUS = 8'h04;
	localparam addr_t ADDR_PATTERN = 8'h08; // write only
	localparam addr_t ADDR_KEY0 = 8'h10;
	localparam addr_t ADDR_KEY1 = 8'h14;
	localparam addr_t ADDR_KEY2 = 8'h18;
	localparam addr_t ADDR_KEY3 = 8'h1C;
	localparam addr_t ADDR_TRNG0 = 8'h20;
	localparam addr_t ADDR_TRNG1 = 8'h24;
	localparam addr_t ADDR_TRNG2 = 8'h28;
	localparam addr_t ADDR_TRNG3 = 8'h2C;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_OP,
		SEL_STATUS,
		SEL_PATTERN,
		SEL_KEY,
		SEL_TRNG
	} reg_sel_t;

	function automatic reg_sel_t reg_sel(addr_t addr);
		case (addr)
			ADDR_OP: return SEL_OP;
			ADDR_STATUS: return SEL_STATUS;
			ADDR_PATTERN: return SEL_PATTERN;
			ADDR_KEY0, ADDR_KEY1, ADDR_KEY2, ADDR_KEY3: return SEL_KEY;
			ADDR_TRNG0, ADDR_TRNG1, ADDR_TRNG2, ADDR_TRNG3: return SEL_TRNG;
			default: return SEL_NONE;
		endcase
	endfunction

	// word index inside the key or trng block
	function automatic sel_word_t reg_word(addr_t addr);
		return addr[3:2];
	endfunction

endpackage

// ==== design/rot_op_pkg.sv ====
package rot_op_pkg;

	localparam int OP_W = 8;

	typedef enum logic [OP_W-1:0] {
		OP_NOP = 8'h00,
		OP_UNLOCK = 8'h01,
		OP_STATUS_CLEAR = 8'h02,
		OP_KEY_CLEAR = 8'h03,
		OP_TRNG_GEN = 8'h04,
		OP_TRNG_CLEAR = 8'h05
	} opcode_t;

	typedef enum logic {
		IDLE = 1'b0,
		CHECK = 1'b1 // walking the pattern bits
	} unlock_state_t;

	typedef struct packed {
		logic busy;
		logic unlock_busy;
		logic trng_valid;
		logic [rot_reg_pkg::TRNG_CNT_W-1:0] trng_count;
		logic [23:0] reserved;
		logic key_loaded;
		logic unlocked;
	} status_fields_t;

	// raw for the bus, fields for the control logic
	typedef union packed {
		rot_reg_pkg::word_t raw;
		status_fields_t f;
	} status_t;

endpackage

// ==== design/rot_if.sv ====
`timescale 1ns/1ps

interface rot_cmd_if;
	import rot_reg_pkg::*;
	import rot_op_pkg::*;

	logic wr_pattern_o;
	logic wr_key_o;
	sel_word_t key_word_o;
	word_t wdata_o;
	logic op_valid_o;
	opcode_t op_o;
	logic bit_o;
	bit_idx_t bit_idx_i; // back from the unlock sequencer

	modport decode (
		output wr_pattern_o, wr_key_o, key_word_o, wdata_o, op_valid_o, op_o, bit_o,
		input bit_idx_i
	);
	modport execute (
		input wr_pattern_o, wr_key_o, key_word_o, wdata_o, op_valid_o, op_o, bit_o,
		output bit_idx_i
	);
endinterface

interface rot_view_if;
	import rot_reg_pkg::*;
	import rot_op_pkg::*;

	status_t status;
	word_t [KEY_WORDS-1:0] key_words;
	word_t [KEY_WORDS-1:0] trng_words;
	opcode_t op_last;

	modport execute (output status, key_words, op_last);
	modport trng (output trng_words);
	modport result (input status, key_words, trng_words, op_last);
endinterface

// ==== design/rot_decode.sv ====
`timescale 1ns/1ps

module rot_decode (
	input rot_reg_pkg::addr_t address_i,
	input rot_reg_pkg::word_t data_i,
	input logic we_i,
	rot_cmd_if.decode cmd
);
	import rot_reg_pkg::*;
	import rot_op_pkg::*;

	reg_sel_t sel;

	assign sel = reg_sel(address_i);

	assign cmd.wr_pattern_o = we_i && (sel == SEL_PATTERN);
	assign cmd.wr_key_o = we_i && (sel == SEL_KEY);
	assign cmd.key_word_o = reg_word(address_i);
	assign cmd.wdata_o = data_i;

	assign cmd.op_valid_o = we_i && (sel == SEL_OP);
	assign cmd.op_o = opcode_t'(data_i[OP_W-1:0]);

	assign cmd.bit_o = data_i[~cmd.bit_idx_i]; // msb first

endmodule

// ==== design/rot_execute.sv ====
`timescale 1ns/1ps

module rot_execute #(
	parameter rot_reg_pkg::word_t PATTERN_INIT = 32'hF0F0_AAAA
) (
	input logic clk,
	input logic rst_n,
	rot_cmd_if.execute cmd,
	rot_view_if.execute view,
	output logic trng_gen_o,
	output logic trng_clear_o,
	input logic [rot_reg_pkg::TRNG_CNT_W-1:0] trng_count_i,
	input logic trng_valid_i
);
	import rot_reg_pkg::*;
	import rot_op_pkg::*;

	unlock_state_t state_q;
	bit_idx_t bit_idx_q;
	logic match_q;
	logic unlocked_q;
	logic key_loaded_q;
	word_t pattern_q;
	word_t [KEY_WORDS-1:0] key_q;
	opcode_t op_last_q;
	status_t status;

	logic open_acc;
	logic op_acc;
	logic unlock_start;
	logic bit_ok;

	assign open_acc = unlocked_q && (state_q == IDLE); // unlocked and not checking
	assign op_acc = cmd.op_valid_o && open_acc;
	assign unlock_start = cmd.op_valid_o && (cmd.op_o == OP_UNLOCK) && (state_q == IDLE);
	assign bit_ok = (cmd.bit_o == pattern_q[~bit_idx_q]);

	assign trng_gen_o = op_acc && (cmd.op_o == OP_TRNG_GEN);
	// a status clear also drops the draw count
	assign trng_clear_o = op_acc &&
		((cmd.op_o == OP_TRNG_CLEAR) || (cmd.op_o == OP_STATUS_CLEAR));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			bit_idx_q <= '0;
			match_q <= 1'b0;
			unlocked_q <= 1'b0;
			key_loaded_q <= 1'b0;
			pattern_q <= PATTERN_INIT;
			key_q <= '0;
			op_last_q <= OP_NOP;
		end else if (state_q == CHECK) begin
			match_q <= match_q && bit_ok;
			bit_idx_q <= bit_idx_q + 1'b1;
			if (bit_idx_q == '1) begin // last bit
				state_q <= IDLE;
				unlocked_q <= match_q && bit_ok;
			end
		end else begin
			if (unlock_start) begin
				state_q <= CHECK;
				bit_idx_q <= '0;
				match_q <= 1'b1;
				op_last_q <= OP_UNLOCK;
			end else if (op_acc) begin
				op_last_q <= cmd.op_o;
			end
			if (op_acc && (cmd.op_o == OP_KEY_CLEAR)) begin
				key_q <= '0;
				key_loaded_q <= 1'b0;
			end
			if (open_acc && cmd.wr_key_o) begin
				key_q[cmd.key_word_o] <= cmd.wdata_o;
				key_loaded_q <= 1'b1;
			end
			if (open_acc && cmd.wr_pattern_o) begin
				pattern_q <= cmd.wdata_o;
			end
		end
	end

	always_comb begin
		status.raw = '0;
		status.f.busy = (state_q == CHECK);
		status.f.unlock_busy = (state_q == CHECK);
		status.f.trng_valid = trng_valid_i;
		status.f.trng_count = trng_count_i;
		status.f.key_loaded = key_loaded_q;
		status.f.unlocked = unlocked_q;
	end

	assign view.status = status;
	assign view.key_words = key_q;
	assign view.op_last = op_last_q;
	assign cmd.bit_idx_i = bit_idx_q;

endmodule

// ==== design/rot_trng.sv ====
`timescale 1ns/1ps

module rot_trng #(
	parameter int unsigned TRNG_MAX_DRAWS = 6,
	parameter rot_reg_pkg::word_t LFSR_SEED = 32'h1ACE_B00C
) (
	input logic clk,
	input logic rst_n,
	input logic gen_i,
	input logic clear_i,
	output logic [rot_reg_pkg::TRNG_CNT_W-1:0] count_o,
	output logic valid_o,
	rot_view_if.trng view
);
	import rot_reg_pkg::*;

	localparam word_t LFSR_MASK = 32'h8020_0003;
	localparam logic [TRNG_CNT_W-1:0] MAX_CNT = TRNG_CNT_W'(TRNG_MAX_DRAWS);

	word_t lfsr_q;
	word_t [KEY_WORDS-1:0] draw;
	word_t [KEY_WORDS-1:0] words_q;
	logic [TRNG_CNT_W-1:0] count_q;
	logic valid_q;

	// galois, shift right, mask on the bit shifted out
	function automatic word_t lfsr_step(word_t s);
		return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
	endfunction

	always_comb begin
		draw[0] = lfsr_step(lfsr_q);
		for (int i = 1; i < KEY_WORDS; i++) begin
			draw[i] = lfsr_step(draw[i-1]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q <= LFSR_SEED;
			words_q <= '0;
			count_q <= '0;
			valid_q <= 1'b0;
		end else if (clear_i) begin
			words_q <= '0; // lfsr keeps running state
			count_q <= '0;
			valid_q <= 1'b0;
		end else if (gen_i && (count_q < MAX_CNT)) begin
			lfsr_q <= draw[KEY_WORDS-1];
			words_q <= draw;
			count_q <= count_q + 1'b1;
			valid_q <= 1'b1;
		end
	end

	assign count_o = count_q;
	assign valid_o = valid_q;
	assign view.trng_words = words_q;

endmodule

// ==== design/rot_result.sv ====
`timescale 1ns/1ps

module rot_result (
	input logic clk,
	input logic rst_n,
	input logic re_i,
	input rot_reg_pkg::addr_t address_i,
	rot_view_if.result view,
	output rot_reg_pkg::word_t data_o
);
	import rot_reg_pkg::*;

	sel_word_t word;
	word_t rdata;

	assign word = reg_word(address_i);

	always_comb begin
		case (reg_sel(address_i))
			SEL_OP: rdata = word_t'(view.op_last);
			SEL_STATUS: rdata = view.status.raw;
			SEL_KEY: rdata = view.key_words[word];
			SEL_TRNG: rdata = view.trng_words[word];
			default: rdata = '0; // pattern never reads back
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_o <= '0;
		end else if (re_i) begin
			data_o <= rdata; // held until next read
		end
	end

endmodule

// ==== design/rot_top.sv ====
`timescale 1ns/1ps

module rot_top #(
	parameter rot_reg_pkg::word_t PATTERN_INIT = 32'hF0F0_AAAA,
	parameter int unsigned TRNG_MAX_DRAWS = 6,
	parameter rot_reg_pkg::word_t LFSR_SEED = 32'h1ACE_B00C
) (
	input logic clk,
	input logic rst_n,
	input rot_reg_pkg::addr_t address_i,
	input rot_reg_pkg::word_t data_i,
	input logic re_i,
	input logic we_i,
	output rot_reg_pkg::word_t data_o
);
	import rot_reg_pkg::*;

	rot_cmd_if cmd_if ();
	rot_view_if view_if ();

	logic trng_gen;
	logic trng_clear;
	logic trng_valid;
	logic [TRNG_CNT_W-1:0] trng_count;

	rot_decode u_decode (
		.address_i (address_i),
		.data_i (data_i),
		.we_i (we_i),
		.cmd (cmd_if.decode)
	);

	rot_execute #(
		.PATTERN_INIT (PATTERN_INIT)
	) u_execute (
		.clk (clk),
		.rst_n (rst_n),
		.cmd (cmd_if.execute),
		.view (view_if.execute),
		.trng_gen_o (trng_gen),
		.trng_clear_o (trng_clear),
		.trng_count_i (trng_count),
		.trng_valid_i (trng_valid)
	);

	rot_trng #(
		.TRNG_MAX_DRAWS (TRNG_MAX_DRAWS),
		.LFSR_SEED (LFSR_SEED)
	) u_trng (
		.clk (clk),
		.rst_n (rst_n),
		.gen_i (trng_gen),
		.clear_i (trng_clear),
		.count_o (trng_count),
		.valid_o (trng_valid),
		.view (view_if.trng)
	);

	rot_result u_result (
		.clk (clk),
		.rst_n (rst_n),
		.re_i (re_i),
		.address_i (address_i),
		.view (view_if.result),
		.data_o (data_o)
	);

endmodule

// ==== sim/rot_tb.sv ====
`timescale 1ns/1ps

module rot_tb;
	import rot_reg_pkg::*;
	import rot_op_pkg::*;

	localparam word_t PATTERN_INIT = 32'hF0F0_AAAA;
	localparam int TRNG_MAX_DRAWS = 6;
	localparam word_t LFSR_SEED = 32'h1ACE_B00C;
	localparam word_t LFSR_MASK = 32'h8020_0003;
	localparam int IDLE_TIMEOUT = 8; // status polls

	logic clk;
	logic rst_n;
	addr_t address;
	word_t wdata;
	logic re;
	logic we;
	word_t rdata;

	integer seed = 44743;
	word_t read_data; // what data_o must hold between reads

	logic m_unlocked;
	logic m_key_loaded;
	logic m_valid;
	logic [2:0] m_count;
	word_t m_pattern;
	word_t m_lfsr;
	word_t m_key [KEY_WORDS];
	word_t m_trng [KEY_WORDS];

	rot_top #(
		.PATTERN_INIT (PATTERN_INIT),
		.TRNG_MAX_DRAWS (TRNG_MAX_DRAWS),
		.LFSR_SEED (LFSR_SEED)
	) uut (
		.clk (clk),
		.rst_n (rst_n),
		.address_i (address),
		.data_i (wdata),
		.re_i (re),
		.we_i (we),
		.data_o (rdata)
	);

	always #2 clk = ~clk;

	task abort_run;
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	hold_check: assert property (@(posedge clk) disable iff (!rst_n) !re |=> (rdata == read_data))
		else begin
			$display("FAIL at %0t ns: data_o changed without a read, expected %h got %h",
				$time, $sampled(read_data), $sampled(rdata));
			abort_run();
		end

	// status word as laid out in the register map
	function automatic word_t status_word(input logic busy);
		return {busy, busy, m_valid, m_count, 24'h0, m_key_loaded, m_unlocked};
	endfunction

	function automatic word_t lfsr_next(input word_t s);
		return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
	endfunction

	task check_value(input string name, input word_t exp);
		read_data = exp;
		assert (rdata === exp) else begin
			$display("FAIL at %0t ns: data_o (%s) expected %h got %h", $time, name, exp, rdata);
			abort_run();
		end
	endtask

	task bus_write(input addr_t a, input word_t d);
		@(posedge clk);
		address <= a;
		wdata <= d;
		we <= 1'b1;
		@(posedge clk);
		we <= 1'b0;
	endtask

	task bus_read(input addr_t a, input word_t exp, input string name);
		@(posedge clk);
		address <= a;
		re <= 1'b1;
		@(posedge clk);
		re <= 1'b0;
		@(negedge clk); // data_o settled
		check_value(name, exp);
	endtask

	task check_key_words;
		for (int i = 0; i < KEY_WORDS; i++) begin
			bus_read(addr_t'(ADDR_KEY0 + 4 * i), m_key[i], $sformatf("key%0d", i));
		end
	endtask

	task check_trng_words;
		for (int i = 0; i < KEY_WORDS; i++) begin
			bus_read(addr_t'(ADDR_TRNG0 + 4 * i), m_trng[i], $sformatf("trng%0d", i));
		end
	endtask

	task clear_trng_model;
		for (int i = 0; i < KEY_WORDS; i++) begin
			m_trng[i] = '0;
		end
		m_count = '0;
		m_valid = 1'b0;
	endtask

	task draw_trng;
		bus_write(ADDR_OP, word_t'(OP_TRNG_GEN));
		if (m_count < TRNG_MAX_DRAWS) begin
			for (int i = 0; i < KEY_WORDS; i++) begin
				m_lfsr = lfsr_next(m_lfsr);
				m_trng[i] = m_lfsr;
			end
			m_count++;
			m_valid = 1'b1;
		end
	endtask

	task wait_idle;
		int polls;
		logic busy;
		polls = 0;
		busy = 1'b1;
		while (busy && (polls < IDLE_TIMEOUT)) begin
			@(posedge clk);
			address <= ADDR_STATUS;
			re <= 1'b1;
			@(posedge clk);
			re <= 1'b0;
			@(negedge clk);
			read_data = rdata;
			busy = rdata[31];
			polls++;
		end
		if (busy) begin
			$display("timeout: unlock check still busy after %0d status reads", polls);
			abort_run();
		end
	endtask

	// opcode, then one pattern bit per cycle msb first, status read every cycle
	task run_unlock(input word_t pat);
		word_t one_hot;
		@(posedge clk);
		address <= ADDR_OP;
		wdata <= word_t'(OP_UNLOCK);
		we <= 1'b1;
		for (int k = 0; k <= 32; k++) begin
			@(posedge clk);
			we <= 1'b0;
			address <= ADDR_STATUS;
			if (k < 32) begin
				re <= 1'b1;
				one_hot = word_t'(1) << (31 - k);
				wdata <= pat[31 - k] ? one_hot : ~one_hot; // other bits carry the opposite
			end else begin
				re <= 1'b0;
				wdata <= '0;
			end
			if (k > 0) begin
				@(negedge clk);
				check_value($sformatf("status in check cycle %0d", k), status_word(1'b1));
			end
		end
		m_unlocked = (pat == m_pattern);
		wait_idle();
		bus_read(ADDR_STATUS, status_word(1'b0), "status after check");
		bus_read(ADDR_OP, word_t'(OP_UNLOCK), "op_last");
	endtask

	initial begin
		word_t bad;
		word_t new_pat;
		clk = 1'b0;
		rst_n = 1'b0;
		address = '0;
		wdata = '0;
		re = 1'b0;
		we = 1'b0;
		read_data = '0;
		m_unlocked = 1'b0;
		m_key_loaded = 1'b0;
		m_pattern = PATTERN_INIT;
		m_lfsr = LFSR_SEED;
		for (int i = 0; i < KEY_WORDS; i++) begin
			m_key[i] = '0;
		end
		clear_trng_model();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		bus_read(ADDR_STATUS, status_word(1'b0), "status");
		bus_read(ADDR_OP, word_t'(OP_NOP), "op_last");
		check_key_words();
		check_trng_words();

		bus_write(ADDR_KEY1, $random(seed)); // locked, dropped
		check_key_words();
		bad = $random(seed);
		if (bad == PATTERN_INIT) begin
			bad = ~bad;
		end
		run_unlock(bad);
		run_unlock(PATTERN_INIT);

		for (int i = 0; i < KEY_WORDS; i++) begin
			m_key[i] = $random(seed);
			bus_write(addr_t'(ADDR_KEY0 + 4 * i), m_key[i]);
		end
		m_key_loaded = 1'b1;
		check_key_words();
		bus_read(ADDR_STATUS, status_word(1'b0), "status");
		bus_write(ADDR_OP, word_t'(OP_KEY_CLEAR));
		for (int i = 0; i < KEY_WORDS; i++) begin
			m_key[i] = '0;
		end
		m_key_loaded = 1'b0;
		check_key_words();
		bus_read(ADDR_STATUS, status_word(1'b0), "status");
		bus_read(ADDR_OP, word_t'(OP_KEY_CLEAR), "op_last");

		// one draw past the limit
		for (int d = 0; d <= TRNG_MAX_DRAWS; d++) begin
			draw_trng();
			check_trng_words();
			bus_read(ADDR_STATUS, status_word(1'b0), "status");
		end
		bus_write(ADDR_OP, word_t'(OP_TRNG_CLEAR));
		clear_trng_model();
		check_trng_words();
		bus_read(ADDR_STATUS, status_word(1'b0), "status");
		draw_trng(); // lfsr carries on after a clear
		check_trng_words();
		bus_write(ADDR_OP, word_t'(OP_STATUS_CLEAR));
		clear_trng_model();
		bus_read(ADDR_STATUS, status_word(1'b0), "status");
		check_trng_words();

		new_pat = $random(seed);
		if (new_pat == PATTERN_INIT) begin
			new_pat = ~new_pat;
		end
		bus_write(ADDR_PATTERN, new_pat);
		m_pattern = new_pat;
		bus_read(ADDR_PATTERN, '0, "pattern");
		run_unlock(PATTERN_INIT);
		run_unlock(new_pat);

		$display("test passed");
		$finish;
	end

endmodule

// ==== flist.f ====
design/rot_reg_pkg.sv
design/rot_op_pkg.sv
design/rot_if.sv
design/rot_decode.sv
design/rot_execute.sv
design/rot_trng.sv
design/rot_result.sv
design/rot_top.sv
sim/rot_tb.sv

// ==== Bender.yml ====
package:
  name: rot_regs

sources:
  - design/rot_reg_pkg.sv
  - design/rot_op_pkg.sv
  - design/rot_if.sv
  - design/rot_decode.sv
  - design/rot_execute.sv
  - design/rot_trng.sv
  - design/rot_result.sv
  - design/rot_top.sv
  - target: test
    files:
      - sim/rot_tb.sv
